// File: flist.f
+incdir+rtl
rtl/screen_geom_pkg.sv
rtl/pixel_color_pkg.sv
rtl/scan_decode.sv
rtl/glyph_rom.sv
rtl/icon_layout_execute.sv
rtl/color_result.sv
rtl/home_renderer.sv
sim/home_checker.sv
sim/tb_home_renderer.sv

// File: rtl/color_result.sv
// Colour lookup and output stage
`timescale 1ns/1ps

`include "home_defines.svh"

module color_result (
    input  logic                          clk,
    input  logic                          reset_n,
    input  pixel_color_pkg::pixel_class_e pix_class,
    input  logic                          class_valid,
    output pixel_color_pkg::rgb565_t      pixel_color,
    output logic                          pixel_valid
);

    import pixel_color_pkg::*;

    rgb565_t next_color;

    // Class to RGB565
    always_comb begin
        case (pix_class)
            class_border:     next_color = `COL_BORDER;
            class_box_fill:   next_color = `COL_BOX;
            class_text:       next_color = `COL_TEXT;
            class_background: next_color = `COL_BG;
            default:          next_color = `COL_BG;
        endcase
    end

    // Colour holds between strobes, valid pulses once per pixel
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pixel_color <= `COL_BG;
            pixel_valid <= 1'b0;
        end else begin
            pixel_valid <= class_valid;
            if (class_valid) begin
                pixel_color <= next_color;
            end
        end
    end

endmodule

// File: rtl/glyph_rom.sv
// 4x7 home screen font
`timescale 1ns/1ps

`include "home_defines.svh"

module glyph_rom (
    input  screen_geom_pkg::char_code_t glyph_char,
    input  screen_geom_pkg::cell_col_t  glyph_col,
    input  screen_geom_pkg::cell_row_t  glyph_row,
    output logic                        glyph_bit
);

    import screen_geom_pkg::*;

    // One bitmap holds all rows of a glyph
    localparam int CELL_BITS = `CHAR_W * `CHAR_H;

    logic [CELL_BITS-1:0] bitmap;
    logic [4:0]           bit_index;
    logic                 in_cell;

    // --------------------
    // Bitmaps
    // --------------------
    // Top row in the high nibble, leftmost column in the nibble MSB
    always_comb begin
        case (glyph_char)
            "G":     bitmap = 28'h788B997;
            "I":     bitmap = 28'hE44444E;
            "F":     bitmap = 28'hF88E888;
            "K":     bitmap = 28'h99ACA99;
            "E":     bitmap = 28'hF88E88F;
            "Y":     bitmap = 28'hAAA4444;
            "C":     bitmap = 28'h7888887;
            "P":     bitmap = 28'hE99E888;
            "4":     bitmap = 28'h26AAF22;
            "3":     bitmap = 28'hE11611E;
            "1":     bitmap = 28'h4C4444E;
            "A":     bitmap = 28'h699F999;
            "D":     bitmap = 28'hE99999E;
            // Space and unknown codes stay blank
            default: bitmap = '0;
        endcase
    end

    // Gap column and rows below the glyph are always blank
    assign in_cell = (glyph_col < cell_col_t'(`CHAR_W)) &&
                     (glyph_row < cell_row_t'(`CHAR_H));

    // --------------------
    // Bit select
    // --------------------
    always_comb begin
        bit_index = '0;
        glyph_bit = 1'b0;
        if (in_cell) begin
            // Row major, counted down from the MSB
            bit_index = 5'(CELL_BITS - 1) -
                        (5'(glyph_row) * 5'(`CHAR_W) + 5'(glyph_col));
            glyph_bit = bitmap[bit_index];
        end
    end

endmodule

// File: rtl/home_defines.svh
// Home screen layout constants
`ifndef HOME_DEFINES_SVH
`define HOME_DEFINES_SVH

// --------------------
// Screen
// --------------------
`define GAME_W        320
`define GAME_H        240

// --------------------
// Icon boxes
// --------------------
`define ICON_W        48
`define ICON_H        48
`define ICON_MARGIN   16
// GIF box sits in the top left corner
`define GIF_ICON_X0   `ICON_MARGIN
// KEYPAD box is centred horizontally, column 136
`define KEY_ICON_X0   ((`GAME_W - `ICON_W) / 2)
`define ICON_Y0       `ICON_MARGIN

// --------------------
// Font and text
// --------------------
`define CHAR_W        4
`define CHAR_H        7
`define CHAR_SPACE    1
`define CHAR_PITCH    (`CHAR_W + `CHAR_SPACE)
// Pixel width of an n character string, no trailing gap
`define TEXT_W(n)     ((n) * `CHAR_PITCH - `CHAR_SPACE)

// String lengths
`define GIF_CAP_CHARS 3
`define KEY_CAP_CHARS 3
`define GIF_LBL_CHARS 7
`define KEY_LBL_CHARS 6

// Captions centred inside the boxes, labels centred under them
`define LABEL_GAP     8
`define LABEL_Y0      (`ICON_Y0 + `ICON_H + `LABEL_GAP)
`define CAPTION_Y0    (`ICON_Y0 + (`ICON_H - `CHAR_H) / 2)
`define GIF_CAP_X0    (`GIF_ICON_X0 + (`ICON_W - `TEXT_W(`GIF_CAP_CHARS)) / 2)
`define KEY_CAP_X0    (`KEY_ICON_X0 + (`ICON_W - `TEXT_W(`KEY_CAP_CHARS)) / 2)
`define GIF_LBL_X0    (`GIF_ICON_X0 + (`ICON_W - `TEXT_W(`GIF_LBL_CHARS)) / 2)
`define KEY_LBL_X0    (`KEY_ICON_X0 + (`ICON_W - `TEXT_W(`KEY_LBL_CHARS)) / 2)

// --------------------
// RGB565 colours
// --------------------
`define PIXEL_BITS    16
`define COL_BG        16'hFFFF
`define COL_TEXT      16'h0000
`define COL_BOX       16'hFFE0
`define COL_BORDER    16'h0000

`endif

// File: rtl/home_renderer.sv
// Home screen renderer top
`timescale 1ns/1ps

`include "home_defines.svh"

module home_renderer #(
    parameter bit FLIP_X = 1'b0,
    parameter bit FLIP_Y = 1'b0
) (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     pixel_strobe,
    output pixel_color_pkg::rgb565_t pixel_color,
    output logic                     pixel_valid
);

    import screen_geom_pkg::*;
    import pixel_color_pkg::*;

    // --------------------
    // Stage links
    // --------------------
    coord_t       game_x;
    coord_t       game_y;
    logic         coord_valid;
    char_code_t   glyph_char;
    cell_col_t    glyph_col;
    cell_row_t    glyph_row;
    logic         glyph_bit;
    pixel_class_e pix_class;
    logic         class_valid;

    // Decode: strobe to registered coordinate
    scan_decode #(
        .FLIP_X (FLIP_X),
        .FLIP_Y (FLIP_Y)
    ) u_scan_decode (
        .clk          (clk),
        .reset_n      (reset_n),
        .pixel_strobe (pixel_strobe),
        .game_x       (game_x),
        .game_y       (game_y),
        .coord_valid  (coord_valid)
    );

    // Execute: coordinate to pixel class
    icon_layout_execute u_icon_layout_execute (
        .clk         (clk),
        .reset_n     (reset_n),
        .game_x      (game_x),
        .game_y      (game_y),
        .coord_valid (coord_valid),
        .glyph_bit   (glyph_bit),
        .glyph_char  (glyph_char),
        .glyph_col   (glyph_col),
        .glyph_row   (glyph_row),
        .pix_class   (pix_class),
        .class_valid (class_valid)
    );

    // Font lookup, same cycle as execute
    glyph_rom u_glyph_rom (
        .glyph_char (glyph_char),
        .glyph_col  (glyph_col),
        .glyph_row  (glyph_row),
        .glyph_bit  (glyph_bit)
    );

    // Result: class to RGB565 output
    color_result u_color_result (
        .clk         (clk),
        .reset_n     (reset_n),
        .pix_class   (pix_class),
        .class_valid (class_valid),
        .pixel_color (pixel_color),
        .pixel_valid (pixel_valid)
    );

endmodule

// File: rtl/icon_layout_execute.sv
// Layout classification stage
`timescale 1ns/1ps

`include "home_defines.svh"

module icon_layout_execute (
    input  logic                          clk,
    input  logic                          reset_n,
    input  screen_geom_pkg::coord_t       game_x,
    input  screen_geom_pkg::coord_t       game_y,
    input  logic                          coord_valid,
    input  logic                          glyph_bit,
    output screen_geom_pkg::char_code_t   glyph_char,
    output screen_geom_pkg::cell_col_t    glyph_col,
    output screen_geom_pkg::cell_row_t    glyph_row,
    output pixel_color_pkg::pixel_class_e pix_class,
    output logic                          class_valid
);

    import screen_geom_pkg::*;
    import pixel_color_pkg::*;

    // Text areas in priority order: GIF caption, KEY caption, two labels
    localparam int          AREA_X0  [4] = '{`GIF_CAP_X0, `KEY_CAP_X0,
                                             `GIF_LBL_X0, `KEY_LBL_X0};
    localparam int          AREA_Y0  [4] = '{`CAPTION_Y0, `CAPTION_Y0,
                                             `LABEL_Y0, `LABEL_Y0};
    localparam int          AREA_LEN [4] = '{`GIF_CAP_CHARS, `KEY_CAP_CHARS,
                                             `GIF_LBL_CHARS, `KEY_LBL_CHARS};
    // Strings right aligned, first character in the highest used byte
    localparam logic [55:0] AREA_STR [4] = '{"GIF", "KEY", "CPE 431", "KEYPAD"};

    region_e      gif_region;
    region_e      key_region;
    region_e      box_region;
    region_e      pix_region;
    logic         text_hit;
    logic [1:0]   text_area;
    coord_t       text_dx;
    coord_t       text_dy;
    logic [2:0]   char_idx;
    pixel_class_e next_class;

    // Edge or inside test for one 48x48 box
    function automatic region_e box_test(coord_t x, coord_t y, coord_t x0);
        coord_t  x1;
        coord_t  y0;
        coord_t  y1;
        region_e r;
        x1 = x0 + coord_t'(`ICON_W - 1);
        y0 = coord_t'(`ICON_Y0);
        y1 = coord_t'(`ICON_Y0 + `ICON_H - 1);
        r  = region_none;
        if (x >= x0 && x <= x1 && y >= y0 && y <= y1) begin
            if (x == x0 || x == x1 || y == y0 || y == y1) begin
                r = region_box_edge;
            end else begin
                r = region_box_inside;
            end
        end
        return r;
    endfunction

    // Inside the span of an n character string
    function automatic logic in_text(coord_t x, coord_t y, int x0, int y0, int n);
        return (int'(x) >= x0) && (int'(x) < x0 + `TEXT_W(n)) &&
               (int'(y) >= y0) && (int'(y) < y0 + `CHAR_H);
    endfunction

    // Character idx of a right aligned string, space past its end
    function automatic char_code_t pick_char(logic [55:0] str, int len, logic [2:0] idx);
        char_code_t c;
        c = " ";
        if (int'(idx) < len) begin
            c = str[8 * (len - 1 - int'(idx)) +: 8];
        end
        return c;
    endfunction

    // --------------------
    // Region tests
    // --------------------
    assign gif_region = box_test(game_x, game_y, coord_t'(`GIF_ICON_X0));
    assign key_region = box_test(game_x, game_y, coord_t'(`KEY_ICON_X0));
    // Boxes never overlap
    assign box_region = (gif_region != region_none) ? gif_region : key_region;

    // Text areas are disjoint, first hit wins
    always_comb begin
        text_hit  = 1'b0;
        text_area = 2'd0;
        for (int i = 0; i < 4; i++) begin
            if (!text_hit && in_text(game_x, game_y, AREA_X0[i], AREA_Y0[i], AREA_LEN[i])) begin
                text_hit  = 1'b1;
                text_area = 2'(i);
            end
        end
    end

    assign pix_region = text_hit ? region_text_area : box_region;

    // --------------------
    // Character select
    // --------------------
    assign text_dx  = game_x - coord_t'(AREA_X0[text_area]);
    assign text_dy  = game_y - coord_t'(AREA_Y0[text_area]);
    // Five column pitch, remainder 4 is the gap
    assign char_idx = 3'(text_dx / coord_t'(`CHAR_PITCH));

    assign glyph_col  = cell_col_t'(text_dx % coord_t'(`CHAR_PITCH));
    assign glyph_row  = cell_row_t'(text_dy);
    assign glyph_char = text_hit ? pick_char(AREA_STR[text_area], AREA_LEN[text_area],
                                             char_idx) : " ";

    // --------------------
    // Classify
    // --------------------
    // Text over box over background
    always_comb begin
        case (pix_region)
            region_box_edge:   next_class = class_border;
            region_box_inside: next_class = class_box_fill;
            region_text_area: begin
                // Captions sit in the box interior, labels on background
                if (glyph_bit) begin
                    next_class = class_text;
                end else if (box_region == region_box_inside) begin
                    next_class = class_box_fill;
                end else begin
                    next_class = class_background;
                end
            end
            default:           next_class = class_background;
        endcase
    end

    always_ff @(posedge clk) begin
        if (coord_valid) begin
            pix_class <= next_class;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            class_valid <= 1'b0;
        end else begin
            class_valid <= coord_valid;
        end
    end

endmodule

// File: rtl/pixel_color_pkg.sv
// Pixel colour types
`include "home_defines.svh"

package pixel_color_pkg;

    // One RGB565 pixel
    // Red in 15:11, green in 10:5, blue in 4:0
    typedef logic [`PIXEL_BITS-1:0] rgb565_t;

    // What a pixel shows, as decided by the execute stage
    typedef enum logic [1:0] {
        class_background,
        class_border,
        class_box_fill,
        class_text
    } pixel_class_e;

endpackage

// File: rtl/scan_decode.sv
// Raster scan decode stage
`timescale 1ns/1ps

`include "home_defines.svh"

module scan_decode #(
    parameter bit FLIP_X = 1'b0,
    parameter bit FLIP_Y = 1'b0
) (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    pixel_strobe,
    output screen_geom_pkg::coord_t game_x,
    output screen_geom_pkg::coord_t game_y,
    output logic                    coord_valid
);

    import screen_geom_pkg::*;

    // Raster position of the next pixel to be drawn
    coord_t scan_x;
    coord_t scan_y;
    logic   last_col;
    logic   last_row;
    // Position after mirroring
    coord_t map_x;
    coord_t map_y;

    assign last_col = (scan_x == coord_t'(`GAME_W - 1));
    assign last_row = (scan_y == coord_t'(`GAME_H - 1));

    // --------------------
    // Raster counter
    // --------------------
    // Same order as the panel: x fastest, one step per strobe
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            scan_x <= '0;
            scan_y <= '0;
        end else if (pixel_strobe) begin
            if (last_col) begin
                scan_x <= '0;
                // Wrap to the top after the last line
                if (last_row) begin
                    scan_y <= '0;
                end else begin
                    scan_y <= scan_y + coord_t'(1);
                end
            end else begin
                scan_x <= scan_x + coord_t'(1);
            end
        end
    end

    // --------------------
    // Mirroring
    // --------------------
    assign map_x = FLIP_X ? coord_t'(`GAME_W - 1) - scan_x : scan_x;
    assign map_y = FLIP_Y ? coord_t'(`GAME_H - 1) - scan_y : scan_y;

    // Coordinates only matter while coord_valid is high
    always_ff @(posedge clk) begin
        if (pixel_strobe) begin
            game_x <= map_x;
            game_y <= map_y;
        end
    end

    // One valid cycle per strobe
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            coord_valid <= 1'b0;
        end else begin
            coord_valid <= pixel_strobe;
        end
    end

endmodule

// File: rtl/screen_geom_pkg.sv
// Screen geometry types
`include "home_defines.svh"

package screen_geom_pkg;

    // Pixel coordinate
    // Sized for the longer axis, 320 needs 9 bits
    typedef logic [$clog2(`GAME_W)-1:0] coord_t;

    // Decoded layout areas
    typedef enum logic [1:0] {
        region_none,
        region_box_edge,
        region_box_inside,
        region_text_area
    } region_e;

    // Plain ASCII character code
    typedef logic [7:0] char_code_t;

    // Column inside a character cell
    // Includes the gap column after the glyph
    typedef logic [$clog2(`CHAR_PITCH)-1:0] cell_col_t;

    // Row inside a character cell
    typedef logic [$clog2(`CHAR_H)-1:0] cell_row_t;

endpackage

// File: run_sim.sh
#!/bin/sh
# Build and run the home renderer testbench with Verilator, plain and mirrored

cd "$(dirname "$0")" || exit 1

run_case() {
    name=$1
    shift
    echo "== $name =="
    verilator --binary --timing -Wno-fatal -f flist.f --top-module tb_home_renderer \
        -Mdir "obj_$name" -o sim_exe "$@"
    if [ $? -ne 0 ]; then
        echo "Build of $name failed"
        return 1
    fi
    "./obj_$name/sim_exe" > "sim_$name.log" 2>&1
    status=$?
    cat "sim_$name.log"
    if [ $status -ne 0 ]; then
        echo "Simulation $name exited with status $status"
        return 1
    fi
    if grep -q "Verification failed" "sim_$name.log"; then
        echo "Simulation $name reported failure"
        return 1
    fi
    return 0
}

result=0
run_case default || result=1
run_case flip_x -GFLIP_X=1 || result=1
exit $result

// File: sim/home_checker.sv
// Home screen reference checker
`timescale 1ns/1ps

`include "home_defines.svh"

module home_checker #(
    parameter bit FLIP_X = 1'b0
) (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     pixel_strobe,
    input  pixel_color_pkg::rgb565_t pixel_color,
    input  logic                     pixel_valid,
    output int                       strobe_count,
    output int                       pixel_count,
    output int                       frame_count,
    output int                       value_errors,
    output int                       timing_errors
);

    import pixel_color_pkg::*;

    localparam int FRAME_PIXELS = `GAME_W * `GAME_H;
    // Text areas: GIF caption, KEY caption, CPE 431 label, KEYPAD label
    localparam int AREA_X0  [4] = '{33, 153, 23, 145};
    localparam int AREA_Y0  [4] = '{36, 36, 72, 72};
    localparam int AREA_LEN [4] = '{3, 3, 7, 6};

    // Model raster position and pixels waiting for output
    int         model_x = 0;
    int         model_y = 0;
    int         exp_q[$];
    // Strobe history, one stage per pipeline register
    logic [2:0] strobe_dly = '0;
    rgb565_t    held_color = `COL_BG;
    int         strobe_cnt = 0;
    int         pixel_cnt  = 0;
    int         frame_cnt  = 0;
    int         value_err  = 0;
    int         timing_err = 0;
    // Ink seen per character cell this frame
    bit         lit [4][7];

    assign strobe_count  = strobe_cnt;
    assign pixel_count   = pixel_cnt;
    assign frame_count   = frame_cnt;
    assign value_errors  = value_err;
    assign timing_errors = timing_err;

    // Colour of the boxes and background alone
    function automatic rgb565_t box_color(int x, int y);
        int x0;
        box_color = `COL_BG;
        for (int b = 0; b < 2; b++) begin
            x0 = (b == 0) ? 16 : 136;
            if (x >= x0 && x < x0 + 48 && y >= 16 && y < 64) begin
                if (x == x0 || x == x0 + 47 || y == 16 || y == 63) begin
                    box_color = `COL_BORDER;
                end else begin
                    box_color = `COL_BOX;
                end
            end
        end
    endfunction

    // Text area index, -1 outside all of them
    function automatic int text_area_at(int x, int y);
        text_area_at = -1;
        for (int a = 0; a < 4; a++) begin
            if (x >= AREA_X0[a] && x < AREA_X0[a] + 5 * AREA_LEN[a] - 1 &&
                y >= AREA_Y0[a] && y < AREA_Y0[a] + 7) begin
                text_area_at = a;
            end
        end
    endfunction

    // Every non-space cell must have shown ink once per frame
    task automatic frame_ink_audit();
        for (int a = 0; a < 4; a++) begin
            for (int c = 0; c < AREA_LEN[a]; c++) begin
                if (!(a == 2 && c == 3) && !lit[a][c]) begin
                    $display("%0t: frame %0d drew no ink in character %0d of text area %0d",
                             $time, frame_cnt, c, a);
                    value_err++;
                end
                lit[a][c] = 1'b0;
            end
        end
        frame_cnt++;
    endtask

    task automatic compare_pixel(int idx);
        int      x;
        int      y;
        int      area;
        int      dx;
        rgb565_t under;
        x     = idx % `GAME_W;
        y     = idx / `GAME_W;
        under = box_color(x, y);
        area  = text_area_at(x, y);
        dx    = (area >= 0) ? x - AREA_X0[area] : 0;
        // Glyph column of a real character, ink or the colour beneath
        if (area >= 0 && dx % 5 != 4 && !(area == 2 && dx / 5 == 3)) begin
            if (pixel_color === `COL_TEXT) begin
                lit[area][dx / 5] = 1'b1;
            end else if (pixel_color !== under) begin
                $display("ERROR %0t pixel_color expected %h or %h actual %h at (%0d,%0d)",
                         $time, `COL_TEXT, under, pixel_color, x, y);
                value_err++;
            end
        end else if (pixel_color !== under) begin
            $display("ERROR %0t pixel_color expected %h actual %h at (%0d,%0d)",
                     $time, under, pixel_color, x, y);
            value_err++;
        end
        pixel_cnt++;
        if (pixel_cnt % FRAME_PIXELS == 0) begin
            frame_ink_audit();
        end
    endtask

    // --------------------
    // Strobe side
    // --------------------
    // Strobes are stable at the rising edge
    always @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            strobe_dly = '0;
            model_x    = 0;
            model_y    = 0;
        end else begin
            strobe_dly = {strobe_dly[1:0], pixel_strobe};
            if (pixel_strobe) begin
                // Mirrored column when FLIP_X is set
                exp_q.push_back(model_y * `GAME_W +
                                (FLIP_X ? `GAME_W - 1 - model_x : model_x));
                strobe_cnt++;
                model_x++;
                if (model_x == `GAME_W) begin
                    model_x = 0;
                    model_y = (model_y == `GAME_H - 1) ? 0 : model_y + 1;
                end
            end
        end
    end

    // --------------------
    // Output side
    // --------------------
    // Outputs are stable at the falling edge
    // Valid rises on the third edge after the strobe and is taken at the next one
    always @(negedge clk) begin
        if (pixel_valid !== strobe_dly[2]) begin
            $display("ERROR %0t pixel_valid expected %0b actual %0b",
                     $time, strobe_dly[2], pixel_valid);
            timing_err++;
        end
        if (pixel_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("%0t: a pixel came out with no strobe waiting for it", $time);
                timing_err++;
            end else begin
                compare_pixel(exp_q.pop_front());
            end
            held_color = pixel_color;
        end else if (pixel_color !== held_color) begin
            // Colour must hold while idle
            $display("ERROR %0t pixel_color expected %h actual %h while idle",
                     $time, held_color, pixel_color);
            value_err++;
        end
    end

endmodule

// File: sim/tb_home_renderer.sv
// Home renderer testbench
`timescale 1ns/1ps

`include "home_defines.svh"

module tb_home_renderer #(
    parameter bit FLIP_X = 1'b0
);

    import pixel_color_pkg::*;

    // One 320x240 frame plus 20 rows, reaching the second frame's boxes
    localparam int          STROBE_TARGET = 83200;
    localparam int          CYCLE_LIMIT   = 200000;
    localparam int          DRAIN_LIMIT   = 20;
    localparam logic [31:0] SEED          = 32'h6aa8_b12f;

    logic    clk;
    logic    reset_n;
    logic    pixel_strobe;
    rgb565_t pixel_color;
    logic    pixel_valid;

    // Counts reported by the checker
    int strobe_count;
    int pixel_count;
    int frame_count;
    int value_errors;
    int timing_errors;
    // Timeouts and short runs
    int run_errors;

    // --------------------
    // Clock
    // --------------------
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    home_renderer #(
        .FLIP_X (FLIP_X),
        .FLIP_Y (1'b0)
    ) u_home_renderer (
        .clk          (clk),
        .reset_n      (reset_n),
        .pixel_strobe (pixel_strobe),
        .pixel_color  (pixel_color),
        .pixel_valid  (pixel_valid)
    );

    home_checker #(
        .FLIP_X (FLIP_X)
    ) u_home_checker (
        .clk           (clk),
        .reset_n       (reset_n),
        .pixel_strobe  (pixel_strobe),
        .pixel_color   (pixel_color),
        .pixel_valid   (pixel_valid),
        .strobe_count  (strobe_count),
        .pixel_count   (pixel_count),
        .frame_count   (frame_count),
        .value_errors  (value_errors),
        .timing_errors (timing_errors)
    );

    // --------------------
    // Stimulus
    // --------------------
    initial begin : stimulus
        int   strobes;
        int   cycles;
        int   run_left;
        int   drain;
        logic burst_on;
        reset_n      = 1'b0;
        pixel_strobe = 1'b0;
        run_errors   = 0;
        void'($urandom(SEED));
        // Reset held for four clock cycles
        repeat (4) @(negedge clk);
        reset_n  = 1'b1;
        strobes  = 0;
        cycles   = 0;
        run_left = 0;
        burst_on = 1'b0;
        // Alternate long strobe bursts with short gaps
        while (strobes < STROBE_TARGET && cycles < CYCLE_LIMIT) begin
            @(negedge clk);
            if (run_left == 0) begin
                burst_on = ($urandom % 4) != 0;
                run_left = burst_on ? 1 + int'($urandom % 600) : 1 + int'($urandom % 30);
            end
            pixel_strobe = burst_on;
            if (burst_on) begin
                strobes++;
            end
            run_left--;
            cycles++;
        end
        @(negedge clk);
        pixel_strobe = 1'b0;
        if (strobes < STROBE_TARGET) begin
            $display("%0t: stimulus ran out of cycles after %0d strobes", $time, strobes);
            run_errors++;
        end
        // Wait for the pipeline to empty
        drain = 0;
        while (strobe_count != pixel_count && drain < DRAIN_LIMIT) begin
            @(negedge clk);
            drain++;
        end
        if (strobe_count != pixel_count) begin
            $display("%0t: timed out waiting for %0d pixels still in flight",
                     $time, strobe_count - pixel_count);
            run_errors++;
        end
        // A few idle cycles catch stray valid pulses
        repeat (4) @(negedge clk);
        if (frame_count < 1) begin
            $display("%0t: the run ended before one whole frame was checked", $time);
            run_errors++;
        end
        $display("Summary: strobes=%0d pixels=%0d frames=%0d errors value=%0d timing=%0d run=%0d",
                 strobe_count, pixel_count, frame_count, value_errors, timing_errors, run_errors);
        if (value_errors == 0 && timing_errors == 0 && run_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
